// ==== logic/jac_types_pkg.sv ====
// datapath types for the 3x3 normal-matrix builder, signed fixed point throughout
// DIM is fixed because the packed structs below are sized by it

package jac_types_pkg;

	// ==========================================================================
	// widths
	// ==========================================================================
	localparam int DIM    = 3;
	localparam int DATA_W = 27;
	// holds 54-bit products summed over up to 1024 samples
	localparam int ACC_W  = 64;

	typedef logic signed [DATA_W-1:0]   data_t;
	typedef logic signed [2*DATA_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0]    acc_t;

	// full-scale limits of a data_t
	localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
	localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

	// ==========================================================================
	// packed containers
	// ==========================================================================
	// one row, diagonal weights or damping terms
	typedef struct packed {
		data_t [DIM-1:0] e;
	} vec_t;

	// raw accumulated matrix, e[row][col]
	typedef struct packed {
		acc_t [DIM-1:0][DIM-1:0] e;
	} acc_mat_t;

	// saturated output matrix
	typedef struct packed {
		data_t [DIM-1:0][DIM-1:0] e;
	} mat_t;

	typedef struct packed {
		vec_t row_a;
		vec_t row_b;
	} sample_t;

	// clamp a wide signed value into the data_t range
	function automatic data_t sat_data(input acc_t x);
		if (x > acc_t'(DATA_MAX))
			return DATA_MAX;
		else if (x < acc_t'(DATA_MIN))
			return DATA_MIN;
		else
			return data_t'(x);
	endfunction

endpackage

// ==== logic/jac_ctrl_pkg.sv ====
// frame sequencing types shared by the counter owner and the accumulator
// a 10-bit counter limits FRAME_LEN to 1024 samples

package jac_ctrl_pkg;

	// ==========================================================================
	// frame counter
	// ==========================================================================
	localparam int FRAME_CNT_W = 10;

	// position of the next sample within its frame
	typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;

	// ==========================================================================
	// per-sample frame flags
	// ==========================================================================
	// only meaningful on cycles where en is high
	typedef struct packed {
		// first sample, accumulator reloads
		logic first;
		// final sample, result follows
		logic last;
	} frame_ctrl_t;

endpackage

// ==== logic/outer_accum.sv ====
// streamed outer-product accumulator building A'B one row pair at a time
// frame_ctrl must be valid on every cycle where en is high

`timescale 1ns/10ps

module outer_accum (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     en,
	input  jac_types_pkg::sample_t   sample,
	input  jac_ctrl_pkg::frame_ctrl_t frame_ctrl,
	output jac_types_pkg::acc_mat_t  acc_mat,
	output logic                     acc_done
);

	// ==========================================================================
	// outer product of the current rows
	// ==========================================================================
	jac_types_pkg::prod_t [jac_types_pkg::DIM-1:0][jac_types_pkg::DIM-1:0] prod;

	always_comb begin
		for (int i = 0; i < jac_types_pkg::DIM; i++) begin
			for (int j = 0; j < jac_types_pkg::DIM; j++) begin
				prod[i][j] = sample.row_a.e[i] * sample.row_b.e[j];
			end
		end
	end

	// ==========================================================================
	// multiply-accumulate cells
	// ==========================================================================
	// first reloads instead of adding, so frames run back to back
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < jac_types_pkg::DIM; i++) begin
				for (int j = 0; j < jac_types_pkg::DIM; j++) begin
					if (frame_ctrl.first)
						acc_mat.e[i][j] <= jac_types_pkg::acc_t'(prod[i][j]);
					else
						acc_mat.e[i][j] <= acc_mat.e[i][j]
							+ jac_types_pkg::acc_t'(prod[i][j]);
				end
			end
		end
	end

	// high for one cycle after the final row of a frame
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_done <= 1'b0;
		end else begin
			acc_done <= en & frame_ctrl.last;
		end
	end

endmodule

// ==== logic/damping_mult.sv ====
// element-wise lambda * diag_w damping terms, one clock of latency
// lambda and diag_w are expected to stay stable across a frame

`timescale 1ns/10ps

module damping_mult #(
	parameter int FRAC = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  jac_types_pkg::data_t lambda,
	input  jac_types_pkg::vec_t  diag_w,
	output jac_types_pkg::vec_t  damp
);

	jac_types_pkg::prod_t [jac_types_pkg::DIM-1:0] prod;
	jac_types_pkg::vec_t                          damp_next;

	// ==========================================================================
	// multiply, rescale, clamp
	// ==========================================================================
	always_comb begin
		for (int i = 0; i < jac_types_pkg::DIM; i++) begin
			prod[i] = lambda * diag_w.e[i];
			// arithmetic shift keeps the floor for negative terms
			damp_next.e[i] = jac_types_pkg::sat_data(
				jac_types_pkg::acc_t'(prod[i] >>> FRAC));
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			damp <= '0;
		end else begin
			damp <= damp_next;
		end
	end

endmodule

// ==== logic/normal_assembler.sv ====
// owns the frame counter and turns the accumulated matrix into the output
// FRAME_LEN must be 1 to 1024, output is shown with a one-cycle strobe only

`timescale 1ns/10ps

module normal_assembler #(
	parameter int FRAME_LEN = 8,
	parameter int FRAC      = 8
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      en,
	output jac_ctrl_pkg::frame_ctrl_t frame_ctrl,
	input  jac_types_pkg::acc_mat_t   acc_mat,
	input  logic                      acc_done,
	input  jac_types_pkg::vec_t       damp,
	output jac_types_pkg::mat_t       normal_mat,
	output logic                      result_valid
);

	localparam jac_ctrl_pkg::frame_cnt_t LAST_CNT = jac_ctrl_pkg::frame_cnt_t'(FRAME_LEN - 1);

	jac_ctrl_pkg::frame_cnt_t frame_cnt;

	// ==========================================================================
	// frame counter
	// ==========================================================================
	// advances on enabled cycles only, holds through gaps in en
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_cnt <= '0;
		end else if (en) begin
			if (frame_cnt == LAST_CNT)
				frame_cnt <= '0;
			else
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// flags for the sample currently on the input
	assign frame_ctrl.first = (frame_cnt == '0);
	assign frame_ctrl.last  = (frame_cnt == LAST_CNT);

	// ==========================================================================
	// rescale, diagonal damping, saturation
	// ==========================================================================
	jac_types_pkg::acc_t [jac_types_pkg::DIM-1:0][jac_types_pkg::DIM-1:0] sum;
	jac_types_pkg::mat_t                                                 mat_next;

	always_comb begin
		for (int i = 0; i < jac_types_pkg::DIM; i++) begin
			for (int j = 0; j < jac_types_pkg::DIM; j++) begin
				// floor divide by 2^FRAC
				sum[i][j] = acc_mat.e[i][j] >>> FRAC;
				if (i == j)
					sum[i][j] = sum[i][j] + jac_types_pkg::acc_t'(damp.e[i]);
				mat_next.e[i][j] = jac_types_pkg::sat_data(sum[i][j]);
			end
		end
	end

	// ==========================================================================
	// output register
	// ==========================================================================
	// normal_mat holds until the next frame completes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			normal_mat   <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= acc_done;
			if (acc_done)
				normal_mat <= mat_next;
		end
	end

endmodule

// ==== logic/jacobian_top.sv ====
// streaming normal-matrix builder, A'B over FRAME_LEN samples plus diagonal damping
// no back-pressure, result_valid is a single-cycle strobe

`timescale 1ns/10ps

module jacobian_top #(
	parameter int FRAME_LEN = 8,
	parameter int FRAC      = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   en,
	input  jac_types_pkg::sample_t sample,
	input  jac_types_pkg::data_t   lambda,
	input  jac_types_pkg::vec_t    diag_w,
	output jac_types_pkg::mat_t    normal_mat,
	output logic                   result_valid
);

	jac_ctrl_pkg::frame_ctrl_t frame_ctrl;
	jac_types_pkg::acc_mat_t   acc_mat;
	logic                      acc_done;
	jac_types_pkg::vec_t       damp;

	// ==========================================================================
	// matrix unit and multiplier array, side by side
	// ==========================================================================
	outer_accum u_outer_accum (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.sample     (sample),
		.frame_ctrl (frame_ctrl),
		.acc_mat    (acc_mat),
		.acc_done   (acc_done)
	);

	damping_mult #(
		.FRAC (FRAC)
	) u_damping_mult (
		.clk    (clk),
		.rst_n  (rst_n),
		.lambda (lambda),
		.diag_w (diag_w),
		.damp   (damp)
	);

	// end-of-frame combine and sequencing
	normal_assembler #(
		.FRAME_LEN (FRAME_LEN),
		.FRAC      (FRAC)
	) u_normal_assembler (
		.clk          (clk),
		.rst_n        (rst_n),
		.en           (en),
		.frame_ctrl   (frame_ctrl),
		.acc_mat      (acc_mat),
		.acc_done     (acc_done),
		.damp         (damp),
		.normal_mat   (normal_mat),
		.result_valid (result_valid)
	);

endmodule

// ==== tb/tb_jacobian.sv ====
// drives jacobian_top with FRAME_LEN 8 and FRAC 8 and changes inputs on the falling edge
// expected matrices come from a local model of the frame rules and are checked in frame order

`timescale 1ns/10ps

module tb_jacobian;

	localparam int FRAME_LEN   = 8;
	localparam int FRAC        = 8;
	// frames over all tests
	localparam int NUM_FRAMES  = 34;
	localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_LEN * 4 * 40 + 2000;
	localparam longint SAT_HI  = 64'sd67108863;
	localparam longint SAT_LO  = -64'sd67108864;
	localparam jac_types_pkg::data_t FULL_POS = jac_types_pkg::data_t'(67108863);
	localparam jac_types_pkg::data_t FULL_NEG = jac_types_pkg::data_t'(-67108864);

	logic                   clk;
	logic                   rst_n;
	logic                   en;
	jac_types_pkg::sample_t sample;
	jac_types_pkg::data_t   lambda;
	jac_types_pkg::vec_t    diag_w;
	jac_types_pkg::mat_t    normal_mat;
	logic                   result_valid;

	jac_types_pkg::sample_t frame_rows [FRAME_LEN];
	jac_types_pkg::mat_t    exp_q [$];
	int                     row_cnt = 0;
	int                     checks  = 0;
	int                     errors  = 0;

	jacobian_top #(
		.FRAME_LEN (FRAME_LEN),
		.FRAC      (FRAC)
	) u_jacobian_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.en           (en),
		.sample       (sample),
		.lambda       (lambda),
		.diag_w       (diag_w),
		.normal_mat   (normal_mat),
		.result_valid (result_valid)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ==========================================================================
	// reference model
	// ==========================================================================
	function automatic longint clamp27(input longint x);
		if (x > SAT_HI)
			return SAT_HI;
		else if (x < SAT_LO)
			return SAT_LO;
		return x;
	endfunction

	// sums each frame from zero and applies the shift, diagonal damping and clamp
	function automatic jac_types_pkg::mat_t ref_normal(input jac_types_pkg::sample_t rows [FRAME_LEN],
			input jac_types_pkg::data_t lam, input jac_types_pkg::vec_t w);
		jac_types_pkg::mat_t m;
		longint              acc;
		longint              d;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				acc = 0;
				for (int k = 0; k < FRAME_LEN; k++)
					acc = acc + longint'(rows[k].row_a.e[i]) * longint'(rows[k].row_b.e[j]);
				acc = acc >>> FRAC;
				if (i == j) begin
					d   = clamp27((longint'(lam) * longint'(w.e[i])) >>> FRAC);
					acc = acc + d;
				end
				m.e[i][j] = jac_types_pkg::data_t'(clamp27(acc));
			end
		end
		return m;
	endfunction

	// ==========================================================================
	// checks and compare
	// ==========================================================================
	task automatic check_val(input string name, input longint got, input longint expv);
		checks++;
		if (got !== expv) begin
			$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, expv);
			errors++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin : compare_results
		jac_types_pkg::mat_t expected;
		if (rst_n && result_valid) begin
			if (exp_q.size() == 0) begin
				$display("error at %0t ns: result_valid with no frame pending", $time);
				errors++;
			end else begin
				expected = exp_q.pop_front();
				for (int i = 0; i < 3; i++)
					for (int j = 0; j < 3; j++)
						check_val($sformatf("normal_mat[%0d][%0d]", i, j),
							longint'(normal_mat.e[i][j]), longint'(expected.e[i][j]));
			end
		end
	end

	// ==========================================================================
	// stimulus helpers
	// ==========================================================================
	function automatic jac_types_pkg::data_t rand_small();
		logic signed [14:0] r;
		r = 15'($urandom);
		return jac_types_pkg::data_t'(r);
	endfunction

	function automatic jac_types_pkg::sample_t rand_sample();
		jac_types_pkg::sample_t s;
		for (int i = 0; i < 3; i++) begin
			s.row_a.e[i] = rand_small();
			s.row_b.e[i] = rand_small();
		end
		return s;
	endfunction

	// en stays high until the next negedge, so follow with another sample or an idle
	task automatic send_sample(input jac_types_pkg::sample_t s);
		@(negedge clk);
		en     = 1'b1;
		sample = s;
		frame_rows[row_cnt] = s;
		row_cnt++;
		if (row_cnt == FRAME_LEN) begin
			exp_q.push_back(ref_normal(frame_rows, lambda, diag_w));
			row_cnt = 0;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			en = 1'b0;
		end
	endtask

	task automatic set_damping(input jac_types_pkg::data_t lam, input jac_types_pkg::vec_t w);
		@(negedge clk);
		en     = 1'b0;
		lambda = lam;
		diag_w = w;
	endtask

	// every pending frame must produce its result within a few cycles
	task automatic wait_results();
		int n;
		idle_cycles(1);
		n = 0;
		while (exp_q.size() != 0 && n < 8) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("error at %0t ns: %0d frame(s) ended with no result", $time, exp_q.size());
			errors = errors + exp_q.size();
			exp_q.delete();
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		$display("test %-14s done, %0d errors", name, errors - err_before);
	endtask

	// ==========================================================================
	// watchdog
	// ==========================================================================
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ==========================================================================
	// test sequence
	// ==========================================================================
	initial begin
		int                     mark;
		jac_types_pkg::sample_t s;
		jac_types_pkg::vec_t    w;
		rst_n  = 1'b0;
		en     = 1'b0;
		sample = '0;
		lambda = '0;
		diag_w = '0;
		void'($urandom(32'h05598d3f));
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// quiet after reset
		mark = errors;
		repeat (20) begin
			@(negedge clk);
			check_val("result_valid", longint'(result_valid), 0);
			for (int i = 0; i < 3; i++)
				for (int j = 0; j < 3; j++)
					check_val($sformatf("normal_mat[%0d][%0d]", i, j),
						longint'(normal_mat.e[i][j]), 0);
		end
		end_test("reset", mark);

		// known rows with no damping, then the result latency
		mark = errors;
		for (int k = 0; k < FRAME_LEN; k++) begin
			s.row_a.e[0] = jac_types_pkg::data_t'(16 * (k + 1));
			s.row_a.e[1] = jac_types_pkg::data_t'(-16 * k);
			s.row_a.e[2] = jac_types_pkg::data_t'(32);
			s.row_b.e[0] = jac_types_pkg::data_t'(16);
			s.row_b.e[1] = jac_types_pkg::data_t'(16 * (k - 3));
			s.row_b.e[2] = jac_types_pkg::data_t'(-48);
			send_sample(s);
		end
		idle_cycles(1);
		check_val("result_valid", longint'(result_valid), 0);
		@(negedge clk);
		check_val("result_valid", longint'(result_valid), 1);
		wait_results();
		end_test("directed", mark);

		mark = errors;
		repeat (20 * FRAME_LEN)
			send_sample(rand_sample());
		wait_results();
		end_test("back_to_back", mark);

		// gaps in en between samples
		mark = errors;
		repeat (4 * FRAME_LEN) begin
			idle_cycles(int'($urandom % 3));
			send_sample(rand_sample());
		end
		wait_results();
		end_test("gaps", mark);

		mark = errors;
		repeat (4) begin
			for (int i = 0; i < 3; i++)
				w.e[i] = rand_small();
			set_damping(rand_small(), w);
			repeat (FRAME_LEN)
				send_sample(rand_sample());
			wait_results();
		end
		end_test("damping", mark);

		// full-scale rows and damping past the 27-bit range
		mark = errors;
		w.e[0] = FULL_NEG;
		w.e[1] = FULL_NEG;
		w.e[2] = FULL_NEG;
		set_damping(FULL_POS, w);
		for (int i = 0; i < 3; i++) begin
			s.row_a.e[i] = FULL_POS;
			s.row_b.e[i] = FULL_POS;
		end
		repeat (FRAME_LEN)
			send_sample(s);
		wait_results();
		w.e[0] = FULL_POS;
		w.e[1] = FULL_POS;
		w.e[2] = FULL_POS;
		set_damping(FULL_NEG, w);
		for (int i = 0; i < 3; i++)
			s.row_b.e[i] = FULL_NEG;
		repeat (FRAME_LEN)
			send_sample(s);
		wait_results();
		s.row_a.e[1] = FULL_NEG;
		s.row_b.e[0] = FULL_POS;
		s.row_b.e[1] = FULL_POS;
		repeat (FRAME_LEN)
			send_sample(s);
		wait_results();
		// small rows where the damping term alone pushes the diagonal out of range
		set_damping(FULL_POS, w);
		for (int i = 0; i < 3; i++) begin
			s.row_a.e[i] = jac_types_pkg::data_t'(16);
			s.row_b.e[i] = jac_types_pkg::data_t'(16);
		end
		repeat (FRAME_LEN)
			send_sample(s);
		wait_results();
		set_damping(FULL_NEG, w);
		for (int i = 0; i < 3; i++)
			s.row_b.e[i] = jac_types_pkg::data_t'(-16);
		repeat (FRAME_LEN)
			send_sample(s);
		wait_results();
		end_test("saturation", mark);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== build.f ====
logic/jac_types_pkg.sv
logic/jac_ctrl_pkg.sv
logic/outer_accum.sv
logic/damping_mult.sv
logic/normal_assembler.sv
logic/jacobian_top.sv
tb/tb_jacobian.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the normal-matrix builder testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_jacobian \
	-f build.f \
	-o sim_jacobian

./obj_dir/sim_jacobian | tee "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation passed"
exit 0
